// File: hdl/debug_defines.svh
`ifndef DEBUG_DEFINES_SVH
`define DEBUG_DEFINES_SVH

////////////////////////////////////////////////////////////
// Snapshot sizes
////////////////////////////////////////////////////////////

`define DEBUG_NUM_REGS        32    // General registers in the dump
`define DEBUG_MEM_WORDS       16    // Data memory window
`define DEBUG_WORD_BYTES      4
`define DEBUG_MEM_ADDR_WIDTH  8
`define DEBUG_COUNT_WIDTH     8     // Byte position in the dump

////////////////////////////////////////////////////////////
// Dump layout
////////////////////////////////////////////////////////////

// PC byte first, then the IF/ID instruction word
`define DEBUG_REG_START       (1 + `DEBUG_WORD_BYTES)
`define DEBUG_MEM_START       (`DEBUG_REG_START + `DEBUG_NUM_REGS * `DEBUG_WORD_BYTES)
`define DEBUG_DUMP_LENGTH     (`DEBUG_MEM_START + `DEBUG_MEM_WORDS * `DEBUG_WORD_BYTES)

`endif

// File: hdl/debug_pkg.sv
`include "debug_defines.svh"

package debug_pkg;

   // Controller states
   typedef enum logic [2:0] {
      INIT = 3'd0,
      IDLE = 3'd1,
      RUN  = 3'd2,     // Free running until end of program
      STEP = 3'd3,     // Waiting for the next step command
      DUMP = 3'd4
   } debugState_t;

   // Command characters from the host
   typedef enum logic [7:0] {
      CMD_RUN  = 8'h63,   // 'c'
      CMD_STEP = 8'h73,   // 's'
      CMD_NEXT = 8'h6e    // 'n'
   } debugCmd_t;

   // Everything observed from the processor for one dump
   typedef struct packed {
      logic [7:0]                           pc;
      logic [31:0]                          instr;   // IF/ID instruction
      logic [`DEBUG_NUM_REGS-1:0][31:0]     regs;    // Register file, index order
   } cpuSnapshot_t;

endpackage

// File: hdl/debugControl.sv
module debugControl (
   input  logic       clock,
   input  logic       reset,
   input  logic [7:0] rxData,
   input  logic       rxValid,
   input  logic       endOfProgram,
   input  logic       dumpDone,
   output logic       rxNext,
   output logic       txWrite,
   output logic       dumping,
   output logic       datapathOn,
   output logic       datapathReset,
   output logic       memSelect,
   output logic       idleLed
);

   debug_pkg::debugState_t state;
   debug_pkg::debugState_t nextState;
   debug_pkg::debugCmd_t   cmd;

   assign cmd = debug_pkg::debugCmd_t'(rxData);

   ////////////////////////////////////////////////////////////
   // State register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         state <= debug_pkg::INIT;
      end else begin
         state <= nextState;
      end
   end

   ////////////////////////////////////////////////////////////
   // Next state and control outputs
   ////////////////////////////////////////////////////////////

   always_comb begin
      nextState     = state;
      rxNext        = 1'b0;
      txWrite       = 1'b0;
      dumping       = 1'b0;
      datapathOn    = 1'b0;
      datapathReset = 1'b0;
      memSelect     = 1'b0;
      idleLed       = 1'b0;

      case (state)
         debug_pkg::INIT: begin
            datapathReset = 1'b1;   // Single cycle of pipeline flush
            nextState     = debug_pkg::IDLE;
         end

         debug_pkg::IDLE: begin
            idleLed       = 1'b1;
            datapathReset = 1'b1;
            rxNext        = rxValid;   // Every character gets popped
            if (rxValid) begin
               case (cmd)
                  debug_pkg::CMD_RUN:  nextState = debug_pkg::RUN;
                  debug_pkg::CMD_STEP: nextState = debug_pkg::STEP;
                  default:             nextState = debug_pkg::IDLE;
               endcase
            end
         end

         debug_pkg::RUN: begin
            datapathOn = 1'b1;
            if (endOfProgram) begin
               nextState = debug_pkg::DUMP;
            end
         end

         debug_pkg::STEP: begin
            rxNext = rxValid;
            // Only a next command clocks the datapath, and only once
            if (rxValid && cmd == debug_pkg::CMD_NEXT) begin
               datapathOn = 1'b1;
               nextState  = debug_pkg::DUMP;
            end
         end

         debug_pkg::DUMP: begin
            dumping   = 1'b1;
            memSelect = 1'b1;        // Memory takes the debug address
            txWrite   = ~dumpDone;
            if (dumpDone) begin
               // Finished program goes back to idle, else keep stepping
               nextState = endOfProgram ? debug_pkg::IDLE : debug_pkg::STEP;
            end
         end

         default: begin
            nextState = debug_pkg::INIT;
         end
      endcase
   end

endmodule

// File: hdl/dumpCounter.sv
`include "debug_defines.svh"

module dumpCounter (
   input  logic                          clock,
   input  logic                          reset,
   input  logic                          dumping,
   input  logic                          byteSent,
   output logic [`DEBUG_COUNT_WIDTH-1:0] count,
   output logic                          dumpDone
);

   localparam logic [`DEBUG_COUNT_WIDTH-1:0] LastCount =
      `DEBUG_COUNT_WIDTH'(`DEBUG_DUMP_LENGTH);

   logic atEnd;

   assign atEnd = (count == LastCount);

   // Position of the byte on offer, held at zero between dumps
   always_ff @(posedge clock) begin
      if (reset || !dumping) begin
         count <= '0;
      end else if (byteSent && !atEnd) begin
         count <= count + 1'b1;   // Saturates at the dump length
      end
   end

   assign dumpDone = atEnd;

endmodule

// File: hdl/dumpByteSelect.sv
`include "debug_defines.svh"

module dumpByteSelect (
   input  debug_pkg::cpuSnapshot_t             snapshot,
   input  logic [31:0]                         memWord,
   input  logic [`DEBUG_COUNT_WIDTH-1:0]       count,
   output logic [7:0]                          byteOut,
   output logic [`DEBUG_MEM_ADDR_WIDTH-1:0]    memAddr
);

   localparam int LaneWidth = $clog2(`DEBUG_WORD_BYTES);

   logic [`DEBUG_COUNT_WIDTH-1:0] instrOffset;
   logic [`DEBUG_COUNT_WIDTH-1:0] regOffset;
   logic [`DEBUG_COUNT_WIDTH-1:0] memOffset;
   logic                          inMem;

   // Byte of a word, lane 0 is the most significant
   function automatic logic [7:0] pickByte(input logic [31:0] word,
                                           input logic [LaneWidth-1:0] lane);
      logic [31:0] shifted;
      shifted = word >> (8 * (`DEBUG_WORD_BYTES - 1 - lane));
      return shifted[7:0];
   endfunction

   assign instrOffset = count - `DEBUG_COUNT_WIDTH'(1);
   assign regOffset   = count - `DEBUG_COUNT_WIDTH'(`DEBUG_REG_START);
   assign memOffset   = count - `DEBUG_COUNT_WIDTH'(`DEBUG_MEM_START);
   assign inMem       = (count >= `DEBUG_MEM_START) && (count < `DEBUG_DUMP_LENGTH);

   ////////////////////////////////////////////////////////////
   // Memory window address
   ////////////////////////////////////////////////////////////

   assign memAddr = inMem ?
      `DEBUG_MEM_ADDR_WIDTH'(memOffset / `DEBUG_WORD_BYTES) : '0;

   ////////////////////////////////////////////////////////////
   // Byte mux
   ////////////////////////////////////////////////////////////

   always_comb begin
      if (count == '0) begin
         byteOut = snapshot.pc;
      end else if (count < `DEBUG_REG_START) begin
         byteOut = pickByte(snapshot.instr, LaneWidth'(instrOffset));
      end else if (count < `DEBUG_MEM_START) begin
         // Four bytes per register, register 0 first
         byteOut = pickByte(snapshot.regs[regOffset / `DEBUG_WORD_BYTES],
                            LaneWidth'(regOffset));
      end else if (inMem) begin
         byteOut = pickByte(memWord, LaneWidth'(memOffset));   // Word already at memAddr
      end else begin
         byteOut = 8'h00;   // Past the end of the dump
      end
   end

endmodule

// File: hdl/debugUnit.sv
`include "debug_defines.svh"

module debugUnit (
   input  logic                             clock,
   input  logic                             reset,
   input  logic                             endOfProgram,
   input  logic [7:0]                       rxData,
   input  logic                             rxValid,
   input  logic                             byteSent,
   input  debug_pkg::cpuSnapshot_t          snapshot,
   input  logic [31:0]                      memWord,
   output logic                             rxNext,
   output logic                             txWrite,
   output logic [7:0]                       byteOut,
   output logic                             datapathOn,
   output logic                             datapathReset,
   output logic                             memSelect,
   output logic [`DEBUG_MEM_ADDR_WIDTH-1:0] memAddr,
   output logic                             idleLed
);

   logic                          dumping;   // Controller in the dump state
   logic                          dumpDone;
   logic [`DEBUG_COUNT_WIDTH-1:0] count;

   debugControl i_debugControl (
      .clock         (clock),
      .reset         (reset),
      .rxData        (rxData),
      .rxValid       (rxValid),
      .endOfProgram  (endOfProgram),
      .dumpDone      (dumpDone),
      .rxNext        (rxNext),
      .txWrite       (txWrite),
      .dumping       (dumping),
      .datapathOn    (datapathOn),
      .datapathReset (datapathReset),
      .memSelect     (memSelect),
      .idleLed       (idleLed)
   );

   dumpCounter i_dumpCounter (
      .clock    (clock),
      .reset    (reset),
      .dumping  (dumping),
      .byteSent (byteSent),
      .count    (count),
      .dumpDone (dumpDone)
   );

   dumpByteSelect i_dumpByteSelect (
      .snapshot (snapshot),
      .memWord  (memWord),
      .count    (count),
      .byteOut  (byteOut),
      .memAddr  (memAddr)
   );

endmodule

// File: dv/debugUnit_assert.sv
module debugUnit_assert (
   input logic       clock,
   input logic       reset,
   input logic       rxNext,
   input logic       rxValid,
   input logic       txWrite,
   input logic       memSelect,
   input logic       idleLed,
   input logic       datapathOn,
   input logic       byteSent,
   input logic [7:0] byteOut
);

   timeunit 1ns;
   timeprecision 100ps;

   int violations = 0;   // Failed assertion count

   popNeedsData: assert property (@(posedge clock) disable iff (reset)
      rxNext |-> rxValid)
      else begin
         violations++;
         $error("rxNext raised while rxValid is low");
      end

   // Dump owns the memory port and the unit is not idle
   dumpOwnsMemory: assert property (@(posedge clock) disable iff (reset)
      txWrite |-> (memSelect && !idleLed))
      else begin
         violations++;
         $error("txWrite high without memSelect or with idleLed");
      end

   // A step clock comes with the pop of its next command
   stepIsOneCycle: assert property (@(posedge clock) disable iff (reset)
      (datapathOn && rxNext) |=> !datapathOn)
      else begin
         violations++;
         $error("datapathOn held longer than one cycle in step mode");
      end

   holdByteOnStall: assert property (@(posedge clock) disable iff (reset)
      (txWrite && !byteSent) |=> $stable(byteOut))
      else begin
         violations++;
         $error("byteOut changed while waiting for byteSent");
      end

endmodule

bind debugUnit debugUnit_assert i_debugUnit_assert (
   .clock      (clock),
   .reset      (reset),
   .rxNext     (rxNext),
   .rxValid    (rxValid),
   .txWrite    (txWrite),
   .memSelect  (memSelect),
   .idleLed    (idleLed),
   .datapathOn (datapathOn),
   .byteSent   (byteSent),
   .byteOut    (byteOut)
);

// File: dv/debugUnit_tb.sv
`include "debug_defines.svh"

module debugUnit_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ClockPeriod = 20;
   localparam int MaxGap      = 4;     // Longest stall between accepted bytes
   localparam int NumDumps    = 4;
   localparam int DumpCycles  = `DEBUG_DUMP_LENGTH * (MaxGap + 2) + 20;

   logic                             clock = 1'b0;
   logic                             reset;
   logic                             endOfProgram;
   logic [7:0]                       rxData;
   logic                             rxValid;
   logic                             byteSent;
   debug_pkg::cpuSnapshot_t          snapshot;
   logic [31:0]                      memWord;
   logic                             rxNext;
   logic                             txWrite;
   logic [7:0]                       byteOut;
   logic                             datapathOn;
   logic                             datapathReset;
   logic                             memSelect;
   logic [`DEBUG_MEM_ADDR_WIDTH-1:0] memAddr;
   logic                             idleLed;

   int    seed;
   int    gapLimit = 0;
   int    gap = 0;
   int    byteCount = 0;
   int    onCycles = 0;
   int    writeCycles = 0;
   string testName = "reset";

   debugUnit i_debugUnit (.*);

   initial begin
      forever #(ClockPeriod / 2) clock = ~clock;
   end

   ////////////////////////////////////////////////////////////
   // Models and reference
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] memPattern(input logic [7:0] addr);
      return {addr ^ 8'ha5, ~addr, addr + 8'h3c, {addr[3:0], addr[7:4]}};
   endfunction

   assign memWord = memSelect ? memPattern(memAddr) : 32'h0;   // Asynchronous read

   function automatic logic [7:0] expectedByte(input int pos);
      logic [31:0] word;
      int          lane;
      if (pos == 0) begin
         return snapshot.pc;
      end else if (pos < `DEBUG_REG_START) begin
         word = snapshot.instr;
         lane = pos - 1;
      end else if (pos < `DEBUG_MEM_START) begin
         word = snapshot.regs[(pos - `DEBUG_REG_START) / `DEBUG_WORD_BYTES];
         lane = (pos - `DEBUG_REG_START) % `DEBUG_WORD_BYTES;
      end else if (pos < `DEBUG_DUMP_LENGTH) begin
         word = memPattern(8'((pos - `DEBUG_MEM_START) / `DEBUG_WORD_BYTES));
         lane = (pos - `DEBUG_MEM_START) % `DEBUG_WORD_BYTES;
      end else begin
         return 8'h00;
      end
      return word[31 - 8 * lane -: 8];   // MSB first
   endfunction

   ////////////////////////////////////////////////////////////
   // Checks and helpers
   ////////////////////////////////////////////////////////////

   task automatic abortRun(input string reason);
      $display("ERROR in %s: %s", testName, reason);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic checkValue(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected) begin
         $display("FAIL %s, %s: expected 0x%0h, actual 0x%0h",
                  testName, what, expected, actual);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic fillSnapshot();
      snapshot.pc    = 8'($random(seed));
      snapshot.instr = $random(seed);
      for (int i = 0; i < `DEBUG_NUM_REGS; i++) begin
         snapshot.regs[i] = $random(seed);
      end
   endtask

   task automatic clearCounters();
      onCycles    = 0;
      writeCycles = 0;
      byteCount   = 0;
   endtask

   task automatic sendChar(input logic [7:0] ch);
      @(negedge clock);
      rxData  = ch;
      rxValid = 1'b1;
      @(posedge clock);
      checkValue("rxNext pop", 1, rxNext);
      @(negedge clock);
      rxValid = 1'b0;
   endtask

   // Returns at the edge that ends the last dump cycle
   task automatic waitDumpEnd();
      int cycles;
      cycles = 0;
      do begin
         @(posedge clock);
         cycles++;
         if (cycles > DumpCycles) abortRun("dump did not start");
      end while (!txWrite);
      do begin
         @(posedge clock);
         cycles++;
         if (cycles > DumpCycles) abortRun("dump did not finish");
      end while (txWrite);
      // Past the last position the byte reads as zero
      checkValue("byte after dump", expectedByte(`DEBUG_DUMP_LENGTH), byteOut);
   endtask

   ////////////////////////////////////////////////////////////
   // Transmit side and compare
   ////////////////////////////////////////////////////////////

   initial begin
      byteSent = 1'b0;
      forever begin
         @(negedge clock);
         if (txWrite && gap == 0) begin
            byteSent = 1'b1;
            gap      = $unsigned($random(seed)) % (gapLimit + 1);
         end else begin
            byteSent = 1'b0;
            if (gap > 0) gap--;
         end
      end
   end

   always @(posedge clock) begin
      if (i_debugUnit.i_debugUnit_assert.violations != 0) abortRun("an assertion failed");
      if (datapathOn) onCycles++;
      if (txWrite) writeCycles++;
      if (txWrite && byteSent) begin
         checkValue($sformatf("byte %0d", byteCount), expectedByte(byteCount), byteOut);
         byteCount++;
      end
   end

   initial begin
      #(ClockPeriod * (NumDumps * DumpCycles + 400));
      abortRun("watchdog expired before the tests finished");
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin
      seed         = 32'h9126_b558;
      reset        = 1'b1;
      endOfProgram = 1'b0;
      rxData       = 8'h00;
      rxValid      = 1'b0;
      snapshot     = '0;
      repeat (3) @(negedge clock);
      checkValue("datapathOn in init", 0, datapathOn);
      checkValue("txWrite in init", 0, txWrite);
      checkValue("rxNext in init", 0, rxNext);
      checkValue("memSelect in init", 0, memSelect);
      checkValue("idleLed in init", 0, idleLed);
      checkValue("datapathReset in init", 1, datapathReset);
      reset = 1'b0;
      @(negedge clock);
      checkValue("idleLed in idle", 1, idleLed);
      checkValue("datapathReset in idle", 1, datapathReset);

      testName = "run to end";
      fillSnapshot();
      clearCounters();
      sendChar(debug_pkg::CMD_RUN);
      checkValue("datapathOn in run", 1, datapathOn);
      checkValue("datapathReset in run", 0, datapathReset);
      repeat (5) @(negedge clock);
      endOfProgram = 1'b1;
      waitDumpEnd();
      @(negedge clock);
      checkValue("datapath ran", 1, onCycles > 0);
      checkValue("bytes in dump", `DEBUG_DUMP_LENGTH, byteCount);
      checkValue("idleLed after run", 1, idleLed);

      testName     = "single step";
      endOfProgram = 1'b0;
      fillSnapshot();
      sendChar(debug_pkg::CMD_STEP);
      clearCounters();
      sendChar(debug_pkg::CMD_NEXT);
      waitDumpEnd();
      repeat (3) @(negedge clock);
      checkValue("step clocks", 1, onCycles);
      checkValue("bytes in dump", `DEBUG_DUMP_LENGTH, byteCount);
      checkValue("idleLed in step", 0, idleLed);
      checkValue("txWrite in step", 0, txWrite);
      checkValue("datapathReset in step", 0, datapathReset);

      testName = "unknown in step";
      clearCounters();
      sendChar(8'h78);
      repeat (4) @(negedge clock);
      checkValue("datapathOn cycles", 0, onCycles);
      checkValue("txWrite cycles", 0, writeCycles);

      testName = "stalled dump";
      gapLimit = MaxGap;
      fillSnapshot();
      clearCounters();
      sendChar(debug_pkg::CMD_NEXT);
      waitDumpEnd();
      @(negedge clock);
      checkValue("bytes in dump", `DEBUG_DUMP_LENGTH, byteCount);
      checkValue("idleLed in step", 0, idleLed);

      testName     = "end in step";
      endOfProgram = 1'b1;
      clearCounters();
      sendChar(debug_pkg::CMD_NEXT);
      waitDumpEnd();
      @(negedge clock);
      checkValue("bytes in dump", `DEBUG_DUMP_LENGTH, byteCount);
      checkValue("idleLed after step", 1, idleLed);

      testName = "unknown in idle";
      clearCounters();
      sendChar(8'h71);
      repeat (4) @(negedge clock);
      checkValue("datapathOn cycles", 0, onCycles);
      checkValue("txWrite cycles", 0, writeCycles);
      checkValue("idleLed", 1, idleLed);

      if (i_debugUnit.i_debugUnit_assert.violations == 0) begin
         $display("Test passed");
         $finish;
      end else begin
         $display("Test failed");
         $fatal(1);
      end
   end

endmodule

// File: compile.f
+incdir+hdl
hdl/debug_pkg.sv
hdl/debugControl.sv
hdl/dumpCounter.sv
hdl/dumpByteSelect.sv
hdl/debugUnit.sv
dv/debugUnit_assert.sv
dv/debugUnit_tb.sv

// File: Bender.yml
package:
  name: debug_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/debug_pkg.sv
      - hdl/debugControl.sv
      - hdl/dumpCounter.sv
      - hdl/dumpByteSelect.sv
      - hdl/debugUnit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/debugUnit_assert.sv
      - dv/debugUnit_tb.sv
